/* hw/command_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module command_decoder import rapcore_pkg::*; (
  input  logic       CLK,
  input  logic       resetn,
  input  logic       word_valid,
  input  spi_word_t  word,
  output drive_cfg_t cfg,
  output logic       move_strobe,
  output move_cmd_t  move,
  output logic       reply_strobe,
  output reply_sel_t reply_sel
);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      cfg          <= '0;
      move_strobe  <= 1'b0;
      reply_strobe <= 1'b0;
      reply_sel    <= reply_none;
    end else begin
      move_strobe  <= 1'b0;
      reply_strobe <= 1'b0;
      if (word_valid) begin
        case (word.cfg.opcode)
          op_cfg_write: begin
            case (word.cfg.addr)
              reg_microsteps: cfg.microsteps <= word.cfg.value[2:0];
              reg_current:    cfg.current <= word.cfg.value[pwm_bits-1:0];
              reg_enable:     cfg.enable <= word.cfg.value[0];
              default: ; // Unknown register
            endcase
          end
          op_move: move_strobe <= 1'b1;
          op_read_encoder: begin
            reply_strobe <= 1'b1;
            reply_sel    <= reply_encoder;
          end
          op_read_status: begin
            reply_strobe <= 1'b1;
            reply_sel    <= reply_status;
          end
          default: ;
        endcase
      end
    end
  end

  // Move payload, valid with move_strobe
  always_ff @(posedge CLK) begin
    if (word_valid && word.move.opcode == op_move) begin
      move.dir         <= word.move.dir;
      move.half_period <= word.move.half_period;
      move.steps       <= word.move.steps;
    end
  end

endmodule

`default_nettype wire

/* hw/hbridge_phase.sv */
`timescale 1ns/1ps
`default_nettype none

module hbridge_phase import rapcore_pkg::*; (
  input  logic       CLK,
  input  logic       resetn,
  input  logic       step,
  input  logic       dir,
  input  drive_cfg_t cfg,
  output logic       phase_a1,
  output logic       phase_a2,
  output logic       phase_b1,
  output logic       phase_b2,
  output logic       vref_a,
  output logic       vref_b
);

  logic                step_q;
  logic [4:0]          position;
  logic [4:0]          increment;
  logic [1:0]          quadrant;
  logic [2:0]          idx;
  logic                a_pos;
  logic                b_pos;
  logic [pwm_bits-1:0] pwm_cnt;
  logic [15:0]         level_a;
  logic [15:0]         level_b;

  // Quarter sine sampled at bin centres
  function automatic logic [7:0] sine_lut(input logic [2:0] i);
    case (i)
      3'd0: sine_lut = 8'd25;
      3'd1: sine_lut = 8'd74;
      3'd2: sine_lut = 8'd120;
      3'd3: sine_lut = 8'd162;
      3'd4: sine_lut = 8'd197;
      3'd5: sine_lut = 8'd225;
      3'd6: sine_lut = 8'd244;
      default: sine_lut = 8'd254;
    endcase
  endfunction

  always_comb begin
    case (cfg.microsteps)
      3'd0: increment = 5'd8;
      3'd1: increment = 5'd4;
      3'd2: increment = 5'd2;
      default: increment = 5'd1;
    endcase
  end

  assign quadrant = position[4:3];
  assign idx      = position[2:0];
  assign a_pos    = ~(quadrant[1] ^ quadrant[0]); // Quadrants 0 and 3
  assign b_pos    = ~quadrant[1];
  // Coil A follows cosine, B follows sine
  assign level_a  = (quadrant[0] ? sine_lut(idx) : sine_lut(~idx)) * cfg.current;
  assign level_b  = (quadrant[0] ? sine_lut(~idx) : sine_lut(idx)) * cfg.current;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      step_q   <= 1'b0;
      position <= '0;
      pwm_cnt  <= '0;
      phase_a1 <= 1'b0;
      phase_a2 <= 1'b0;
      phase_b1 <= 1'b0;
      phase_b2 <= 1'b0;
      vref_a   <= 1'b0;
      vref_b   <= 1'b0;
    end else begin
      step_q  <= step;
      pwm_cnt <= pwm_cnt + 1'b1;
      if (step && !step_q) position <= dir ? position + increment : position - increment;
      phase_a1 <= cfg.enable & a_pos;
      phase_a2 <= cfg.enable & ~a_pos;
      phase_b1 <= cfg.enable & b_pos;
      phase_b2 <= cfg.enable & ~b_pos;
      vref_a   <= cfg.enable && (level_a[15:8] > pwm_cnt);
      vref_b   <= cfg.enable && (level_b[15:8] > pwm_cnt);
    end
  end

endmodule

`default_nettype wire

/* hw/move_executor.sv */
`timescale 1ns/1ps
`default_nettype none

module move_executor import rapcore_pkg::*; (
  input  logic        CLK,
  input  logic        resetn,
  input  logic        enable,
  input  logic        move_strobe,
  input  move_cmd_t   move,
  output logic        step,
  output logic        dir,
  output move_state_t state
);

  logic        busy;
  logic        done;
  logic        rejected;
  logic [31:0] remaining;
  logic [15:0] half_period;
  logic [15:0] timer;
  logic        toggle;

  // Half period of 0 or 1 toggles every cycle
  assign toggle = ({1'b0, timer} + 17'd1) >= {1'b0, half_period};

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      busy      <= 1'b0;
      done      <= 1'b0;
      rejected  <= 1'b0;
      step      <= 1'b0;
      dir       <= 1'b0;
      remaining <= '0;
      timer     <= '0;
    end else begin
      done     <= 1'b0;
      rejected <= 1'b0;
      if (move_strobe) begin
        if (busy || !enable || move.steps == 32'd0) begin
          rejected <= 1'b1;
        end else begin
          busy      <= 1'b1;
          dir       <= move.dir;
          remaining <= move.steps;
          timer     <= '0;
          step      <= 1'b0;
        end
      end
      if (busy) begin
        if (toggle) begin
          timer <= '0;
          step  <= ~step;
          if (!step) begin
            remaining <= remaining - 32'd1; // Rising edge
          end else if (remaining == 32'd0) begin
            busy <= 1'b0;
            done <= 1'b1;
          end
        end else begin
          timer <= timer + 16'd1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (move_strobe && !busy) half_period <= move.half_period;
  end

  assign state.busy      = busy;
  assign state.done      = done;
  assign state.rejected  = rejected;
  assign state.remaining = remaining;

endmodule

`default_nettype wire

/* hw/quad_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module quad_encoder import rapcore_pkg::*; (
  input  logic               CLK,
  input  logic               resetn,
  input  logic               a,
  input  logic               b,
  output logic signed [63:0] count,
  output logic               fault
);

  logic [1:0] a_sync;
  logic [1:0] b_sync;
  logic       a_prev;
  logic       b_prev;
  logic       a_chg;
  logic       b_chg;
  logic       count_en;
  logic       up;

  assign a_chg    = a_sync[1] ^ a_prev;
  assign b_chg    = b_sync[1] ^ b_prev;
  assign count_en = a_chg ^ b_chg; // Exactly one input moved
  assign up       = a_sync[1] ^ b_prev; // A leading

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      a_sync <= 2'b00;
      b_sync <= 2'b00;
      a_prev <= 1'b0;
      b_prev <= 1'b0;
      count  <= '0;
      fault  <= 1'b0;
    end else begin
      a_sync <= {a_sync[0], a};
      b_sync <= {b_sync[0], b};
      a_prev <= a_sync[1];
      b_prev <= b_sync[1];
      fault  <= a_chg & b_chg;
      if (count_en) count <= up ? count + 64'sd1 : count - 64'sd1;
    end
  end

endmodule

`default_nettype wire

/* hw/rapcore_pkg.sv */
`default_nettype none

package rapcore_pkg;

  localparam int word_bits = 64;
  localparam int pwm_bits  = 8;

  localparam logic [7:0] op_cfg_write    = 8'h10;
  localparam logic [7:0] op_move         = 8'h20;
  localparam logic [7:0] op_read_encoder = 8'h30;
  localparam logic [7:0] op_read_status  = 8'h40;

  localparam logic [7:0] reg_microsteps = 8'd0;
  localparam logic [7:0] reg_current    = 8'd1;
  localparam logic [7:0] reg_enable     = 8'd2;

  typedef struct packed {
    logic [7:0]  opcode;
    logic [7:0]  addr;
    logic [15:0] rsvd;
    logic [31:0] value;
  } cfg_view_t;

  typedef struct packed {
    logic [7:0]  opcode;
    logic        dir;
    logic [6:0]  rsvd;
    logic [15:0] half_period; // CLK cycles
    logic [31:0] steps;
  } move_view_t;

  // Same 64 bits, read as either a register write or a move
  typedef union packed {
    cfg_view_t  cfg;
    move_view_t move;
  } spi_word_t;

  typedef struct packed {
    logic [2:0]          microsteps;
    logic [pwm_bits-1:0] current;
    logic                enable;
  } drive_cfg_t;

  typedef struct packed {
    logic        dir;
    logic [15:0] half_period;
    logic [31:0] steps;
  } move_cmd_t;

  typedef struct packed {
    logic        busy;
    logic        done;     // One cycle
    logic        rejected; // One cycle
    logic [31:0] remaining;
  } move_state_t;

  typedef enum logic [1:0] {
    reply_none    = 2'd0,
    reply_encoder = 2'd1,
    reply_status  = 2'd2
  } reply_sel_t;

endpackage

`default_nettype wire

/* hw/rapcore_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rapcore_top import rapcore_pkg::*; (
  input  logic CLK,
  input  logic resetn,
  input  logic sck,
  input  logic cs,   // Active low
  input  logic copi,
  output logic cipo,
  input  logic enc_a,
  input  logic enc_b,
  output logic step,
  output logic dir,
  output logic enable,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2,
  output logic vref_a,
  output logic vref_b
);

  spi_word_t          rx_word;
  spi_word_t          reply;
  logic               word_valid;
  drive_cfg_t         cfg;
  logic               move_strobe;
  move_cmd_t          move;
  logic               reply_strobe;
  reply_sel_t         reply_sel;
  move_state_t        move_state;
  logic signed [63:0] encoder_count;
  logic               encoder_fault;

  assign enable = cfg.enable;

  spi_peripheral spi0 (
    .CLK(CLK), .resetn(resetn), .sck(sck), .cs(cs), .copi(copi), .cipo(cipo),
    .reply(reply), .word_valid(word_valid), .word(rx_word)
  );

  command_decoder decode0 (
    .CLK(CLK), .resetn(resetn), .word_valid(word_valid), .word(rx_word),
    .cfg(cfg), .move_strobe(move_strobe), .move(move),
    .reply_strobe(reply_strobe), .reply_sel(reply_sel)
  );

  move_executor execute0 (
    .CLK(CLK), .resetn(resetn), .enable(cfg.enable), .move_strobe(move_strobe),
    .move(move), .step(step), .dir(dir), .state(move_state)
  );

  status_reporter result0 (
    .CLK(CLK), .resetn(resetn), .state(move_state), .cfg(cfg),
    .encoder_count(encoder_count), .encoder_fault(encoder_fault),
    .reply_strobe(reply_strobe), .reply_sel(reply_sel), .reply(reply)
  );

  quad_encoder encoder0 (
    .CLK(CLK), .resetn(resetn), .a(enc_a), .b(enc_b),
    .count(encoder_count), .fault(encoder_fault)
  );

  hbridge_phase bridge0 (
    .CLK(CLK), .resetn(resetn), .step(step), .dir(dir), .cfg(cfg),
    .phase_a1(phase_a1), .phase_a2(phase_a2), .phase_b1(phase_b1),
    .phase_b2(phase_b2), .vref_a(vref_a), .vref_b(vref_b)
  );

endmodule

`default_nettype wire

/* hw/spi_peripheral.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_peripheral import rapcore_pkg::*; (
  input  logic      CLK,
  input  logic      resetn,
  input  logic      sck,
  input  logic      cs,
  input  logic      copi,
  output logic      cipo,
  input  spi_word_t reply,
  output logic      word_valid,
  output spi_word_t word
);

  logic [2:0] sck_q;
  logic [2:0] cs_q;
  logic [1:0] copi_q;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_fall;
  logic       cs_rise;
  logic       selected;
  logic [word_bits-1:0] shift_in;
  logic [word_bits-1:0] shift_out;
  logic [6:0] bit_cnt;

  // Two sync stages, third flop for edge detect
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_q  <= 3'b000;
      cs_q   <= 3'b111;
      copi_q <= 2'b00;
    end else begin
      sck_q  <= {sck_q[1:0], sck};
      cs_q   <= {cs_q[1:0], cs};
      copi_q <= {copi_q[0], copi};
    end
  end

  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign cs_fall  = ~cs_q[1] & cs_q[2];
  assign cs_rise  = cs_q[1] & ~cs_q[2];
  assign selected = ~cs_q[1];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      shift_out  <= '0;
      bit_cnt    <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= cs_rise && (bit_cnt == 7'd64); // Short or long frames dropped
      if (cs_fall) begin
        shift_out <= reply;
        bit_cnt   <= '0;
      end else if (selected) begin
        if (sck_fall) shift_out <= {shift_out[word_bits-2:0], 1'b0};
        if (sck_rise && bit_cnt != 7'h7f) bit_cnt <= bit_cnt + 7'd1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (selected && sck_rise) shift_in <= {shift_in[word_bits-2:0], copi_q[1]};
    if (cs_rise) word <= shift_in;
  end

  assign cipo = shift_out[word_bits-1]; // MSB first

endmodule

`default_nettype wire

/* hw/status_reporter.sv */
`timescale 1ns/1ps
`default_nettype none

module status_reporter import rapcore_pkg::*; (
  input  logic               CLK,
  input  logic               resetn,
  input  move_state_t        state,
  input  drive_cfg_t         cfg,
  input  logic signed [63:0] encoder_count,
  input  logic               encoder_fault,
  input  logic               reply_strobe,
  input  reply_sel_t         reply_sel,
  output spi_word_t          reply
);

  logic [15:0] done_count;
  logic [15:0] reject_count;
  logic        fault_sticky;
  logic [word_bits-1:0] status_word;

  assign status_word = {state.busy, fault_sticky, 2'b00, cfg,
                        reject_count, done_count, state.remaining[15:0]};

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      done_count   <= '0;
      reject_count <= '0;
      fault_sticky <= 1'b0;
    end else begin
      if (state.done) done_count <= done_count + 16'd1;
      if (state.rejected) reject_count <= reject_count + 16'd1;
      if (encoder_fault) fault_sticky <= 1'b1; // Cleared only by reset
    end
  end

  // Shifted out on the next frame
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      reply <= '0;
    end else if (reply_strobe) begin
      case (reply_sel)
        reply_encoder: reply <= spi_word_t'(encoder_count);
        reply_status:  reply <= spi_word_t'(status_word);
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* sim.f */
hw/rapcore_pkg.sv
hw/spi_peripheral.sv
hw/command_decoder.sv
hw/move_executor.sv
hw/status_reporter.sv
hw/quad_encoder.sv
hw/hbridge_phase.sv
hw/rapcore_top.sv
verification/rapcore_tb.sv

/* verification/rapcore_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rapcore_tb import rapcore_pkg::*; ();

  logic CLK = 1'b0;
  logic resetn, sck, cs, copi, enc_a, enc_b;
  logic cipo, step, dir, enable;
  logic phase_a1, phase_a2, phase_b1, phase_b2, vref_a, vref_b;

  int          errors = 0;
  int          checks = 0;
  logic [15:0] lfsr = 16'd27879;
  // Reference model
  logic [2:0]  m_ms = '0;
  logic [7:0]  m_cur = '0;
  logic        m_en = 1'b0;
  logic        m_fault = 1'b0;
  logic        m_dir = 1'b0;
  logic [4:0]  m_pos = '0;
  logic [15:0] m_dones = '0;
  logic [15:0] m_rejects = '0;
  logic signed [63:0] m_count = '0;
  logic [1:0]  enc_idx = '0; // Gray position of A/B
  int          rise_total = 0;
  int          phase_wait = 0;
  logic        step_seen = 1'b0;

  rapcore_top dut0 (
    .CLK(CLK), .resetn(resetn), .sck(sck), .cs(cs), .copi(copi), .cipo(cipo),
    .enc_a(enc_a), .enc_b(enc_b), .step(step), .dir(dir), .enable(enable),
    .phase_a1(phase_a1), .phase_a2(phase_a2), .phase_b1(phase_b1),
    .phase_b2(phase_b2), .vref_a(vref_a), .vref_b(vref_b)
  );

  always #5 CLK = ~CLK;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16+x^14+x^13+x^11+1
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [4:0] step_inc(input logic [2:0] ms);
    case (ms)
      3'd0: return 5'd8;
      3'd1: return 5'd4;
      3'd2: return 5'd2;
      default: return 5'd1;
    endcase
  endfunction

  // {a1, a2, b1, b2} per full-step quadrant
  function automatic logic [3:0] phase_pattern(input logic [4:0] p, input logic en);
    if (!en) return 4'b0000;
    case (p[4:3])
      2'd0: return 4'b1010;
      2'd1: return 4'b0110;
      2'd2: return 4'b0101;
      default: return 4'b1001;
    endcase
  endfunction

  function automatic logic [63:0] expected_status();
    return {1'b0, m_fault, 2'b00, m_ms, m_cur, m_en, m_rejects, m_dones, 16'h0};
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_waited(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("Timed out at %0t while waiting for %s", $time, what);
    end
  endtask

  // Step edges, dir and phase outputs, sampled mid-cycle
  always @(negedge CLK) begin
    if (phase_wait > 0) begin
      phase_wait--;
      if (phase_wait == 0)
        check_value("phase_a1/a2/b1/b2", {phase_a1, phase_a2, phase_b1, phase_b2},
                    phase_pattern(m_pos, m_en));
    end
    if (resetn && step && !step_seen) begin
      rise_total++;
      check_value("dir", dir, m_dir);
      m_pos = m_dir ? m_pos + step_inc(m_ms) : m_pos - step_inc(m_ms);
      phase_wait = 2; // Edge detect plus output register
    end
    step_seen = step;
  end

  task automatic spi_frame(input logic [63:0] tx, input int nbits, output logic [63:0] rx);
    int i;
    rx = '0;
    @(posedge CLK);
    cs <= 1'b0;
    repeat (8) @(posedge CLK);
    for (i = 0; i < nbits; i++) begin
      copi <= tx[63-i];
      repeat (8) @(posedge CLK);
      sck <= 1'b1;
      rx[63-i] = cipo; // Mode 0
      repeat (8) @(posedge CLK);
      sck <= 1'b0;
    end
    repeat (8) @(posedge CLK);
    cs <= 1'b1;
    repeat (8) @(posedge CLK);
  endtask

  task automatic write_cfg(input logic [7:0] addr, input logic [31:0] value);
    logic [63:0] rx;
    spi_frame({op_cfg_write, addr, 16'h0, value}, 64, rx);
  endtask

  task automatic send_move(input logic d, input logic [15:0] half, input logic [31:0] steps);
    logic [63:0] rx;
    spi_frame({op_move, d, 7'h0, half, steps}, 64, rx);
  endtask

  // Request, then fetch on the following frame
  task automatic read_reply(input logic [7:0] op, output logic [63:0] r);
    logic [63:0] rx;
    spi_frame({op, 56'h0}, 64, rx);
    spi_frame(64'h0, 64, r);
  endtask

  task automatic finish_move(input int base, input int steps, input int half);
    int   t;
    logic stray;
    t = 0;
    while (rise_total - base < steps && t < 2 * steps * half + 2000) begin
      @(posedge CLK);
      t++;
    end
    check_waited(rise_total - base == steps, "step rising edges");
    t = 0;
    while (dut0.execute0.busy && t < 4 * half + 20) begin
      @(posedge CLK);
      t++;
    end
    check_waited(!dut0.execute0.busy, "end of move");
    stray = 1'b0;
    repeat (2 * half + 8) begin
      @(posedge CLK);
      stray |= step;
    end
    check_value("step after move", stray, 0);
    check_value("step rising edges", rise_total - base, steps);
  endtask

  task automatic enc_drive();
    @(posedge CLK);
    enc_a <= enc_idx[1] ^ enc_idx[0];
    enc_b <= enc_idx[1];
    repeat (4) @(posedge CLK);
  endtask

  task automatic enc_move(input logic up);
    enc_idx = up ? enc_idx + 2'd1 : enc_idx - 2'd1;
    m_count = up ? m_count + 64'sd1 : m_count - 64'sd1;
    enc_drive();
  endtask

  initial begin
    logic [63:0] r;
    logic [31:0] v;
    logic [31:0] steps;
    logic [15:0] half;
    logic        d;
    int          base;
    int          nbits;
    logic [63:0] cmd;
    resetn = 1'b0;
    sck    = 1'b0;
    cs     = 1'b1;
    copi   = 1'b0;
    enc_a  = 1'b0;
    enc_b  = 1'b0;
    repeat (4) @(posedge CLK);
    resetn <= 1'b1;
    repeat (4) @(posedge CLK);

    rand_bits(3, v);
    m_ms = v[2:0];
    write_cfg(reg_microsteps, {29'h0, m_ms});
    rand_bits(8, v);
    m_cur = v[7:0];
    write_cfg(reg_current, {24'h0, m_cur});
    write_cfg(reg_enable, 32'd1);
    m_en = 1'b1;
    check_value("enable", enable, m_en);
    read_reply(op_read_status, r);
    check_value("status", r, expected_status());

    repeat (3) begin
      rand_bits(1, v);
      d = v[0];
      rand_bits(6, v);
      steps = v % 40 + 1;
      rand_bits(5, v);
      half = v % 19 + 2;
      m_dir = d;
      base = rise_total;
      send_move(d, half, steps);
      finish_move(base, steps, half);
      m_dones++;
    end

    // Long move, a second one lands while busy
    rand_bits(1, v);
    d = v[0];
    m_dir = d;
    base = rise_total;
    send_move(d, 16'd20, 32'd40);
    send_move(~d, 16'd3, 32'd5);
    m_rejects++;
    finish_move(base, 40, 20);
    m_dones++;
    write_cfg(reg_enable, 32'd0);
    m_en = 1'b0;
    check_value("enable/phases/vref while disabled",
                {enable, phase_a1, phase_a2, phase_b1, phase_b2, vref_a, vref_b}, 0);
    send_move(d, 16'd4, 32'd3);
    m_rejects++;
    read_reply(op_read_status, r);
    check_value("status", r, expected_status());
    write_cfg(reg_enable, 32'd1);
    m_en = 1'b1;

    rand_bits(6, steps);
    repeat (steps) begin
      rand_bits(1, v);
      enc_move(v[0]);
    end
    read_reply(op_read_encoder, r);
    check_value("encoder count", r, m_count);
    enc_idx = enc_idx + 2'd2; // A and B together
    m_fault = 1'b1;
    enc_drive();
    read_reply(op_read_status, r);
    check_value("status", r, expected_status());

    rand_bits(6, v);
    nbits = (v[5:0] == 6'd0) ? 1 : v[5:0];
    cmd = {op_cfg_write, reg_current, 16'h0, 24'h0, ~m_cur};
    // Shift register holds the head of cmd, the short frame carries its tail
    spi_frame(cmd >> nbits, 64, r);
    spi_frame(cmd << (64 - nbits), nbits, r);
    read_reply(op_read_status, r);
    check_value("status after short frame", r, expected_status());

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
